/* idli_decode.f */
+incdir+verification
hdl/idli_isa_pkg.sv
hdl/idli_dcd_pkg.sv
hdl/idli_dcd_seq.sv
hdl/idli_dcd_operand.sv
hdl/idli_dcd_ctrl.sv
hdl/idli_decode.sv
verification/idli_decode_tb.sv

/* Makefile */
# Verilator flow for the nibble-serial decoder.
# Override any variable on the command line, for example make sim TOP=...

VERILATOR ?= verilator
TOP       ?= idli_decode_tb
FILELIST  ?= idli_decode.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

/* verification/idli_decode_vectors.svh */
`ifndef IDLI_DECODE_VECTORS_SVH
`define IDLI_DECODE_VECTORS_SVH

// Each row gives the name, the 16-bit encoding with nibble 0 in bits 15:12,
// whether an immediate follows, the redirect in the fourth cycle, the expected
// op valid, the expected operands (p, q, a, b, c, a_vld, b_vld, c_vld, q_vld),
// the expected controls (lhs, rhs, alu, cin, inv, cmp, signed, wr_pc, wr_lr,
// p_inv) and a flag that leaves the ALU op unchecked.
task automatic load_vectors();
  // ALU group with A=5, B=3, C=2 and P=1.
  add_vector("add", 16'hC35A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("sub", 16'hCB5A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("and", 16'hD35A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_AND, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("andn", 16'hDB5A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_AND, 0, 1, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("or", 16'hE35A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_OR, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("xor", 16'hEB5A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_XOR, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);

  // Comparisons writing Q=2. Nibble 1 bit 0 doubles as A bit 2.
  add_vector("eq", 16'h429A, 0, 0, 1, make_opnd(1, 2, 2, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_EQ, 1, 0, 0, 0), 0);
  add_vector("ne", 16'h439A, 0, 0, 1, make_opnd(1, 2, 6, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_NE, 1, 0, 0, 0), 0);
  add_vector("lt", 16'h4A9A, 0, 0, 1, make_opnd(1, 2, 2, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_LT, 1, 0, 0, 0), 0);
  add_vector("ltu", 16'h4B9A, 0, 0, 1, make_opnd(1, 2, 6, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_LT, 0, 0, 0, 0), 0);
  add_vector("ge", 16'h529A, 0, 0, 1, make_opnd(1, 2, 2, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_GE, 1, 0, 0, 0), 0);
  add_vector("geu", 16'h539A, 0, 0, 1, make_opnd(1, 2, 6, 3, 2, 0, 1, 1, 1),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_GE, 0, 0, 0, 0), 0);

  // Branches and moves. BZ keeps the ALU op of the instruction before it.
  add_vector("bz", 16'h031C, 0, 0, 1, make_opnd(3, 0, 4, 3, 4, 0, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 1, 0, 0), 1);
  add_vector("bp", 16'hFC05, 0, 0, 1, make_opnd(2, 0, 0, 0, 5, 0, 0, 1, 0),
             make_ctrl(LHS_PC, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 1, 0, 0), 0);
  add_vector("bpf", 16'hFC15, 0, 0, 1, make_opnd(2, 0, 0, 2, 5, 0, 0, 1, 0),
             make_ctrl(LHS_PC, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 1, 0, 1), 0);
  add_vector("jpl", 16'hFC65, 0, 0, 1, make_opnd(2, 1, 1, 4, 5, 0, 0, 1, 0),
             make_ctrl(LHS_ZERO, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 1, 1, 0), 0);
  add_vector("mov", 16'hF78B, 0, 0, 1, make_opnd(3, 2, 6, 1, 3, 1, 0, 1, 0),
             make_ctrl(LHS_ZERO, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("movpc", 16'hF79B, 0, 0, 1, make_opnd(3, 2, 6, 3, 3, 1, 0, 1, 0),
             make_ctrl(LHS_PC, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);

  // A NOP produces nothing, and the OR after it must still decode.
  add_vector("nop", 16'h0000, 0, 0, 0, make_opnd(0, 0, 0, 0, 0, 0, 0, 0, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 1);
  add_vector("or_after_nop", 16'hE35A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_OR, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);

  // C=7 reads an immediate, which is skipped unless execute redirects.
  add_vector("add_imm", 16'hC35F, 1, 0, 1, make_opnd(1, 1, 5, 3, 7, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_IMM, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("xor_after_imm", 16'hEB5A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_XOR, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("add_imm_redirect", 16'hC35F, 1, 1, 1, make_opnd(1, 1, 5, 3, 7, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_IMM, ALU_ADD, 0, 0, CMP_EQ, 0, 0, 0, 0), 0);
  add_vector("sub_after_redirect", 16'hCB5A, 0, 0, 1, make_opnd(1, 1, 5, 3, 2, 1, 1, 1, 0),
             make_ctrl(LHS_REG, RHS_REG, ALU_ADD, 1, 1, CMP_EQ, 0, 0, 0, 0), 0);
endtask

`endif

/* verification/idli_decode_tb.sv */
`timescale 1ns/1ps

// Table-driven testbench for the nibble-serial decoder.
module idli_decode_tb;

  // Limits for the whole run and for each wait on op valid.
  localparam int WATCHDOG_NS = 20000;
  localparam int VLD_WAIT_NS = 4;

  // Short names for the expected values in the vector table.
  localparam idli_isa_pkg::lhs_src_t LHS_REG  = idli_isa_pkg::LHS_SRC_REG;
  localparam idli_isa_pkg::lhs_src_t LHS_PC   = idli_isa_pkg::LHS_SRC_PC;
  localparam idli_isa_pkg::lhs_src_t LHS_ZERO = idli_isa_pkg::LHS_SRC_ZERO;
  localparam idli_isa_pkg::rhs_src_t RHS_REG  = idli_isa_pkg::RHS_SRC_REG;
  localparam idli_isa_pkg::rhs_src_t RHS_IMM  = idli_isa_pkg::RHS_SRC_IMM;
  localparam idli_isa_pkg::alu_op_t  ALU_ADD  = idli_isa_pkg::ALU_OP_ADD;
  localparam idli_isa_pkg::alu_op_t  ALU_AND  = idli_isa_pkg::ALU_OP_AND;
  localparam idli_isa_pkg::alu_op_t  ALU_OR   = idli_isa_pkg::ALU_OP_OR;
  localparam idli_isa_pkg::alu_op_t  ALU_XOR  = idli_isa_pkg::ALU_OP_XOR;
  localparam idli_isa_pkg::cmp_op_t  CMP_EQ   = idli_isa_pkg::CMP_OP_EQ;
  localparam idli_isa_pkg::cmp_op_t  CMP_NE   = idli_isa_pkg::CMP_OP_NE;
  localparam idli_isa_pkg::cmp_op_t  CMP_LT   = idli_isa_pkg::CMP_OP_LT;
  localparam idli_isa_pkg::cmp_op_t  CMP_GE   = idli_isa_pkg::CMP_OP_GE;

  // One row of the vector table.
  typedef struct {
    string               name;
    logic [15:0]         enc;
    logic                has_imm;
    logic                redirect;
    logic                exp_vld;
    idli_isa_pkg::opnd_t exp_opnd;
    idli_isa_pkg::ctrl_t exp_ctrl;
    logic                alu_dc;
  } vector_t;

  logic                    i_dcd_gck;
  logic                    i_dcd_rst_n;
  idli_isa_pkg::sqi_data_t i_dcd_enc;
  logic                    i_dcd_enc_vld;
  logic                    i_dcd_ex_redirect;
  idli_isa_pkg::op_t       o_dcd_op;
  logic                    o_dcd_op_vld;

  vector_t vectors[$];
  integer  seed = 32'h1fb7;

  idli_decode dut (
    .i_dcd_gck,
    .i_dcd_rst_n,
    .i_dcd_enc,
    .i_dcd_enc_vld,
    .i_dcd_ex_redirect,
    .o_dcd_op,
    .o_dcd_op_vld
  );

  function automatic idli_isa_pkg::opnd_t make_opnd(input int p, input int q, input int a,
                                                    input int b, input int c, input int av,
                                                    input int bv, input int cv, input int qv);
    idli_isa_pkg::opnd_t o;
    o.p     = idli_isa_pkg::preg_t'(p);
    o.q     = idli_isa_pkg::preg_t'(q);
    o.a     = idli_isa_pkg::greg_t'(a);
    o.b     = idli_isa_pkg::greg_t'(b);
    o.c     = idli_isa_pkg::greg_t'(c);
    o.a_vld = av != 0;
    o.b_vld = bv != 0;
    o.c_vld = cv != 0;
    o.q_vld = qv != 0;
    return o;
  endfunction

  function automatic idli_isa_pkg::ctrl_t make_ctrl(
      input idli_isa_pkg::lhs_src_t lhs, input idli_isa_pkg::rhs_src_t rhs,
      input idli_isa_pkg::alu_op_t alu, input int cin, input int inv,
      input idli_isa_pkg::cmp_op_t cmp, input int sgn, input int pc, input int lr,
      input int pinv);
    idli_isa_pkg::ctrl_t c;
    c.lhs_src     = lhs;
    c.rhs_src     = rhs;
    c.alu_op      = alu;
    c.alu_cin     = cin != 0;
    c.alu_rhs_inv = inv != 0;
    c.cmp_op      = cmp;
    c.cmp_signed  = sgn != 0;
    c.wr_pc       = pc != 0;
    c.wr_lr       = lr != 0;
    c.p_inv       = pinv != 0;
    return c;
  endfunction

  task automatic add_vector(input string name, input logic [15:0] enc, input logic has_imm,
                            input logic redirect, input logic exp_vld,
                            input idli_isa_pkg::opnd_t exp_opnd,
                            input idli_isa_pkg::ctrl_t exp_ctrl, input logic alu_dc);
    vector_t v;
    v.name     = name;
    v.enc      = enc;
    v.has_imm  = has_imm;
    v.redirect = redirect;
    v.exp_vld  = exp_vld;
    v.exp_opnd = exp_opnd;
    v.exp_ctrl = exp_ctrl;
    v.alu_dc   = alu_dc;
    vectors.push_back(v);
  endtask

  `include "idli_decode_vectors.svh"

  // Prints the reason, then ends the run as a failure.
  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Drives one nibble on the falling edge. No operation may appear before the
  // fourth nibble of an instruction or during immediate data.
  task automatic drive_quiet_nibble(input string name, input idli_isa_pkg::sqi_data_t nib);
    @(negedge i_dcd_gck);
    i_dcd_enc         = nib;
    i_dcd_enc_vld     = 1'b1;
    i_dcd_ex_redirect = 1'b0;
    #1;
    assert (o_dcd_op_vld === 1'b0)
      else stop_on_error($sformatf("FAILED %s op_vld expected 0 actual %b", name, o_dcd_op_vld));
  endtask

  task automatic apply_vector(input vector_t v);
    idli_isa_pkg::ctrl_t ctrl_mask;
    int                  waited;
    for (int i = 0; i < 3; i++) begin
      drive_quiet_nibble(v.name, v.enc[15 - 4*i -: 4]);
    end

    // The fourth nibble completes the instruction, optionally with redirect.
    @(negedge i_dcd_gck);
    i_dcd_enc         = v.enc[3:0];
    i_dcd_enc_vld     = 1'b1;
    i_dcd_ex_redirect = v.redirect;

    if (v.exp_vld) begin
      // The result is due in this cycle, so the wait ends before the next edge.
      waited = 0;
      do begin
        #1;
        waited++;
      end while (o_dcd_op_vld !== 1'b1 && waited < VLD_WAIT_NS);
      assert (o_dcd_op_vld === 1'b1)
        else stop_on_error($sformatf("Timed out in %s waiting for op_vld", v.name));

      assert (o_dcd_op.opnd === v.exp_opnd)
        else stop_on_error($sformatf("FAILED %s opnd expected %h actual %h",
                                     v.name, v.exp_opnd, o_dcd_op.opnd));

      // BZ takes its ALU op from the previous instruction, so it is masked.
      ctrl_mask = '1;
      if (v.alu_dc) begin
        ctrl_mask.alu_op = idli_isa_pkg::alu_op_t'(2'b00);
      end
      assert ((o_dcd_op.ctrl & ctrl_mask) === (v.exp_ctrl & ctrl_mask))
        else stop_on_error($sformatf("FAILED %s ctrl expected %h actual %h",
                                     v.name, v.exp_ctrl & ctrl_mask,
                                     o_dcd_op.ctrl & ctrl_mask));
    end else begin
      #1;
      assert (o_dcd_op_vld === 1'b0)
        else stop_on_error($sformatf("FAILED %s op_vld expected 0 actual %b",
                                     v.name, o_dcd_op_vld));
    end

    // Random immediate data follows unless execute redirected.
    if (v.has_imm && !v.redirect) begin
      for (int i = 0; i < 4; i++) begin
        drive_quiet_nibble({v.name, "_imm"}, idli_isa_pkg::sqi_data_t'($random(seed)));
      end
    end
  endtask

  initial begin
    i_dcd_gck = 1'b0;
    forever #5 i_dcd_gck = ~i_dcd_gck;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Simulation did not finish within the time limit");
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    i_dcd_rst_n       = 1'b0;
    i_dcd_enc         = '0;
    i_dcd_enc_vld     = 1'b0;
    i_dcd_ex_redirect = 1'b0;
    load_vectors();

    repeat (4) @(posedge i_dcd_gck);
    @(negedge i_dcd_gck);
    i_dcd_rst_n = 1'b1;
    #1;
    assert (o_dcd_op_vld === 1'b0)
      else stop_on_error($sformatf("FAILED reset op_vld expected 0 actual %b", o_dcd_op_vld));

    foreach (vectors[i]) begin
      apply_vector(vectors[i]);
    end

    @(negedge i_dcd_gck);
    i_dcd_enc_vld     = 1'b0;
    i_dcd_ex_redirect = 1'b0;
    $display("Regression passed");
    $finish;
  end

endmodule

/* hdl/idli_decode.sv */
`timescale 1ns/1ps

// Nibble-serial instruction decoder. The sequencer tracks progress through
// the instruction while the two decoders build the operands and the
// controls, and the result is presented with the fourth nibble.
module idli_decode (
  // Clock and reset.
  input  var logic                    i_dcd_gck,
  input  var logic                    i_dcd_rst_n,

  // Instruction nibble and whether it is valid.
  input  var idli_isa_pkg::sqi_data_t i_dcd_enc,
  input  var logic                    i_dcd_enc_vld,

  // Execute has redirected and the immediate must not be skipped.
  input  var logic                    i_dcd_ex_redirect,

  // Decoded operation and whether it is valid.
  output var idli_isa_pkg::op_t       o_dcd_op,
  output var logic                    o_dcd_op_vld
);

  // Decode progress shared by both decoders.
  idli_dcd_pkg::state_t   state;
  idli_dcd_pkg::cycle_t   cycle;
  logic                   capture;

  // Live decoder outputs.
  idli_isa_pkg::opnd_t    opnd;
  idli_isa_pkg::ctrl_t    ctrl;
  idli_isa_pkg::rhs_src_t rhs_src;

  idli_dcd_seq u_seq (
    .i_dcd_gck,
    .i_dcd_rst_n,
    .i_dcd_enc,
    .i_dcd_enc_vld,
    .i_dcd_ex_redirect,
    .i_seq_rhs_src (rhs_src),
    .o_seq_state   (state),
    .o_seq_cycle   (cycle),
    .o_seq_capture (capture),
    .o_dcd_op_vld
  );

  idli_dcd_operand u_operand (
    .i_dcd_gck,
    .i_dcd_enc,
    .i_opnd_state   (state),
    .i_opnd_cycle   (cycle),
    .i_opnd_capture (capture),
    .o_opnd         (opnd)
  );

  idli_dcd_ctrl u_ctrl (
    .i_dcd_gck,
    .i_dcd_enc,
    .i_ctrl_state   (state),
    .i_ctrl_capture (capture),
    .o_ctrl         (ctrl),
    .o_ctrl_rhs_src (rhs_src)
  );

  // The operation is the live view of both halves so execute sees it in the
  // cycle of the final nibble.
  always_comb begin
    o_dcd_op.opnd = opnd;
    o_dcd_op.ctrl = ctrl;
  end

endmodule

/* hdl/idli_dcd_ctrl.sv */
`timescale 1ns/1ps

// Control decoder. Each control is settled in the state that reveals it and
// then carried through the states that follow, so the final cycle presents
// the full set of execute controls.
module idli_dcd_ctrl (
  // Clock.
  input  var logic                    i_dcd_gck,

  // Current instruction nibble.
  input  var idli_isa_pkg::sqi_data_t i_dcd_enc,

  // Decode progress from the sequencer.
  input  var idli_dcd_pkg::state_t    i_ctrl_state,
  input  var logic                    i_ctrl_capture,

  // Controls including the current nibble.
  output var idli_isa_pkg::ctrl_t     o_ctrl,

  // Live rhs source so the sequencer can skip the immediate.
  output var idli_isa_pkg::rhs_src_t  o_ctrl_rhs_src
);

  // Controls settled on earlier nibbles, and the live view.
  idli_isa_pkg::ctrl_t ctrl_q;
  idli_isa_pkg::ctrl_t ctrl_d;

  always_comb begin
    // Flags clear unless a state sets or keeps them. The lhs source and
    // the ALU op carry over until a state replaces them.
    ctrl_d         = '0;
    ctrl_d.lhs_src = ctrl_q.lhs_src;
    ctrl_d.alu_op  = ctrl_q.alu_op;
    ctrl_d.cmp_op  = idli_isa_pkg::CMP_OP_EQ;

    // C arrives in the final nibble, and 7 there selects the immediate.
    if (i_dcd_enc[2:0] == idli_isa_pkg::GREG_IMM) begin
      ctrl_d.rhs_src = idli_isa_pkg::RHS_SRC_IMM;
    end else begin
      ctrl_d.rhs_src = idli_isa_pkg::RHS_SRC_REG;
    end

    case (i_ctrl_state)
      idli_dcd_pkg::STATE_ADD_SUB: begin
        // SUB adds the inverted rhs with a carry in.
        ctrl_d.alu_op      = idli_isa_pkg::ALU_OP_ADD;
        ctrl_d.alu_cin     = i_dcd_enc[3];
        ctrl_d.alu_rhs_inv = i_dcd_enc[3];
      end
      idli_dcd_pkg::STATE_AND_ANDN: begin
        ctrl_d.alu_op      = idli_isa_pkg::ALU_OP_AND;
        ctrl_d.alu_rhs_inv = i_dcd_enc[3];
      end
      idli_dcd_pkg::STATE_OR_XOR: begin
        if (i_dcd_enc[3]) begin
          ctrl_d.alu_op = idli_isa_pkg::ALU_OP_XOR;
        end else begin
          ctrl_d.alu_op = idli_isa_pkg::ALU_OP_OR;
        end
      end
      idli_dcd_pkg::STATE_EQ_LT: begin
        // Comparisons subtract and test the result.
        ctrl_d.alu_op      = idli_isa_pkg::ALU_OP_ADD;
        ctrl_d.alu_cin     = 1'b1;
        ctrl_d.alu_rhs_inv = 1'b1;
        case ({i_dcd_enc[3], i_dcd_enc[0]})
          2'b00:   ctrl_d.cmp_op = idli_isa_pkg::CMP_OP_EQ;
          2'b01:   ctrl_d.cmp_op = idli_isa_pkg::CMP_OP_NE;
          default: ctrl_d.cmp_op = idli_isa_pkg::CMP_OP_LT;
        endcase

        // Only LTU has both bits set.
        ctrl_d.cmp_signed = ~&{i_dcd_enc[3], i_dcd_enc[0]};
      end
      idli_dcd_pkg::STATE_GE: begin
        ctrl_d.alu_op      = idli_isa_pkg::ALU_OP_ADD;
        ctrl_d.alu_cin     = 1'b1;
        ctrl_d.alu_rhs_inv = 1'b1;
        ctrl_d.cmp_op      = idli_isa_pkg::CMP_OP_GE;
        ctrl_d.cmp_signed  = i_dcd_enc[3] | ~i_dcd_enc[0];
      end
      idli_dcd_pkg::STATE_MOV_PC_BP_JP: begin
        // Moves and branch targets add the lhs to the rhs.
        ctrl_d.alu_op = idli_isa_pkg::ALU_OP_ADD;
      end
      idli_dcd_pkg::STATE_BZ: begin
        ctrl_d.wr_pc = 1'b1;
      end
      idli_dcd_pkg::STATE_BP_JP: begin
        // Jumps name a register in bits 3:2 and so have no PC base.
        ctrl_d.wr_pc = 1'b1;
        ctrl_d.wr_lr = i_dcd_enc[1];
        ctrl_d.p_inv = i_dcd_enc[0];
        if (|i_dcd_enc[3:2]) begin
          ctrl_d.lhs_src = idli_isa_pkg::LHS_SRC_ZERO;
        end else begin
          ctrl_d.lhs_src = idli_isa_pkg::LHS_SRC_PC;
        end
      end
      idli_dcd_pkg::STATE_MOV_PC: begin
        if (i_dcd_enc[0]) begin
          ctrl_d.lhs_src = idli_isa_pkg::LHS_SRC_PC;
        end else begin
          ctrl_d.lhs_src = idli_isa_pkg::LHS_SRC_ZERO;
        end
      end
      idli_dcd_pkg::STATE_QBC: begin
        ctrl_d.alu_cin     = ctrl_q.alu_cin;
        ctrl_d.alu_rhs_inv = ctrl_q.alu_rhs_inv;
        ctrl_d.cmp_op      = ctrl_q.cmp_op;
        ctrl_d.cmp_signed  = ctrl_q.cmp_signed;
      end
      idli_dcd_pkg::STATE_ABC: begin
        ctrl_d.lhs_src     = idli_isa_pkg::LHS_SRC_REG;
        ctrl_d.alu_cin     = ctrl_q.alu_cin;
        ctrl_d.alu_rhs_inv = ctrl_q.alu_rhs_inv;
      end
      idli_dcd_pkg::STATE_BC: begin
        // Reached from ALU, compare and branch on zero paths alike.
        ctrl_d.lhs_src     = idli_isa_pkg::LHS_SRC_REG;
        ctrl_d.alu_cin     = ctrl_q.alu_cin;
        ctrl_d.alu_rhs_inv = ctrl_q.alu_rhs_inv;
        ctrl_d.cmp_op      = ctrl_q.cmp_op;
        ctrl_d.cmp_signed  = ctrl_q.cmp_signed;
        ctrl_d.wr_pc       = ctrl_q.wr_pc;
      end
      idli_dcd_pkg::STATE_C: begin
        ctrl_d.wr_pc = ctrl_q.wr_pc;
        ctrl_d.wr_lr = ctrl_q.wr_lr;
        ctrl_d.p_inv = ctrl_q.p_inv;
      end
      default: begin
        // NOP and immediate states add no controls.
      end
    endcase
  end

  always_ff @(posedge i_dcd_gck) begin
    if (i_ctrl_capture) begin
      ctrl_q <= ctrl_d;
    end
  end

  always_comb o_ctrl = ctrl_d;

  always_comb o_ctrl_rhs_src = ctrl_d.rhs_src;

endmodule

/* hdl/idli_dcd_operand.sv */
`timescale 1ns/1ps

// Operand field extraction. Register fields sit at the same nibble positions
// in every supported instruction, so they are placed by cycle alone. Only
// the valid flags and the fixed predicate of a branch on zero depend on the
// decode state.
module idli_dcd_operand (
  // Clock.
  input  var logic                    i_dcd_gck,

  // Current instruction nibble.
  input  var idli_isa_pkg::sqi_data_t i_dcd_enc,

  // Decode progress from the sequencer.
  input  var idli_dcd_pkg::state_t    i_opnd_state,
  input  var idli_dcd_pkg::cycle_t    i_opnd_cycle,
  input  var logic                    i_opnd_capture,

  // Operand fields including the current nibble.
  output var idli_isa_pkg::opnd_t     o_opnd
);

  // Fields gathered on earlier nibbles, and the live view that merges in
  // the current one.
  idli_isa_pkg::opnd_t opnd_q;
  idli_isa_pkg::opnd_t opnd_d;

  always_comb begin
    opnd_d = opnd_q;

    case (i_opnd_cycle)
      2'd1: begin
        // Branch on zero is not predicated, so it always uses PT.
        if (i_opnd_state == idli_dcd_pkg::STATE_NOP_BZ) begin
          opnd_d.p = idli_isa_pkg::PREG_PT;
        end else begin
          opnd_d.p = i_dcd_enc[2:1];
        end
        opnd_d.a[2]  = i_dcd_enc[0];

        // Only comparisons write a predicate.
        opnd_d.q_vld = i_opnd_state == idli_dcd_pkg::STATE_EQ_LT
                    || i_opnd_state == idli_dcd_pkg::STATE_GE;
      end
      2'd2: begin
        // Q and the low bits of A share the same nibble bits.
        opnd_d.q      = i_dcd_enc[3:2];
        opnd_d.a[1:0] = i_dcd_enc[3:2];
        opnd_d.b[2:1] = i_dcd_enc[1:0];
        opnd_d.a_vld  = i_opnd_state == idli_dcd_pkg::STATE_ABC
                     || i_opnd_state == idli_dcd_pkg::STATE_MOV_PC;
      end
      2'd3: begin
        opnd_d.b[0]  = i_dcd_enc[3];
        opnd_d.c     = i_dcd_enc[2:0];
        opnd_d.b_vld = i_opnd_state == idli_dcd_pkg::STATE_BC;
        opnd_d.c_vld = i_opnd_state == idli_dcd_pkg::STATE_BC
                    || i_opnd_state == idli_dcd_pkg::STATE_C;
      end
      default: begin
        // The first nibble is the opcode and carries no operand bits.
      end
    endcase
  end

  always_ff @(posedge i_dcd_gck) begin
    if (i_opnd_capture) begin
      opnd_q <= opnd_d;
    end
  end

  always_comb o_opnd = opnd_d;

endmodule

/* hdl/idli_dcd_seq.sv */
`timescale 1ns/1ps

// Decode sequencer. It follows the opcode path over the four nibbles of an
// instruction and steps over the four immediate nibbles when an instruction
// reads an immediate.
module idli_dcd_seq (
  // Clock and reset.
  input  var logic                    i_dcd_gck,
  input  var logic                    i_dcd_rst_n,

  // Instruction nibble and whether it is valid.
  input  var idli_isa_pkg::sqi_data_t i_dcd_enc,
  input  var logic                    i_dcd_enc_vld,

  // Redirect from execute.
  input  var logic                    i_dcd_ex_redirect,

  // Live rhs source of the instruction in its final cycle.
  input  var idli_isa_pkg::rhs_src_t  i_seq_rhs_src,

  // Decode progress for the field decoders.
  output var idli_dcd_pkg::state_t    o_seq_state,
  output var idli_dcd_pkg::cycle_t    o_seq_cycle,
  output var logic                    o_seq_capture,

  // Decoded operation is valid.
  output var logic                    o_dcd_op_vld
);

  // Current and next decode state.
  idli_dcd_pkg::state_t state_q;
  idli_dcd_pkg::state_t state_d;

  always_ff @(posedge i_dcd_gck or negedge i_dcd_rst_n) begin
    if (!i_dcd_rst_n) begin
      state_q <= idli_dcd_pkg::STATE_INIT;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;

    case (state_q)
      idli_dcd_pkg::STATE_INIT: begin
        // Wait for the first nibble, which is the opcode. Unsupported
        // opcodes follow the NOP path so the whole instruction is consumed.
        if (i_dcd_enc_vld) begin
          case (i_dcd_enc)
            4'b0100: state_d = idli_dcd_pkg::STATE_EQ_LT;
            4'b0101: state_d = idli_dcd_pkg::STATE_GE;
            4'b1100: state_d = idli_dcd_pkg::STATE_ADD_SUB;
            4'b1101: state_d = idli_dcd_pkg::STATE_AND_ANDN;
            4'b1110: state_d = idli_dcd_pkg::STATE_OR_XOR;
            4'b1111: state_d = idli_dcd_pkg::STATE_MOV_PC_BP_JP;
            default: state_d = idli_dcd_pkg::STATE_NOP_BZ;
          endcase
        end
      end
      idli_dcd_pkg::STATE_NOP_BZ: begin
        // Nibble 1 tells a branch on zero apart from a NOP.
        if (i_dcd_enc[3:1] == 3'b001) begin
          state_d = idli_dcd_pkg::STATE_BZ;
        end else begin
          state_d = idli_dcd_pkg::STATE_NOP_0;
        end
      end
      idli_dcd_pkg::STATE_EQ_LT,
      idli_dcd_pkg::STATE_GE: begin
        // The comparison is fully known, so only Q, B and C remain.
        state_d = idli_dcd_pkg::STATE_QBC;
      end
      idli_dcd_pkg::STATE_ADD_SUB,
      idli_dcd_pkg::STATE_AND_ANDN,
      idli_dcd_pkg::STATE_OR_XOR: begin
        state_d = idli_dcd_pkg::STATE_ABC;
      end
      idli_dcd_pkg::STATE_MOV_PC_BP_JP: begin
        // Branches and jumps set the top bit, moves leave it clear.
        if (i_dcd_enc[3]) begin
          state_d = idli_dcd_pkg::STATE_BP_JP;
        end else begin
          state_d = idli_dcd_pkg::STATE_MOV_PC;
        end
      end
      idli_dcd_pkg::STATE_BZ,
      idli_dcd_pkg::STATE_QBC,
      idli_dcd_pkg::STATE_ABC: state_d = idli_dcd_pkg::STATE_BC;
      idli_dcd_pkg::STATE_BP_JP,
      idli_dcd_pkg::STATE_MOV_PC: state_d = idli_dcd_pkg::STATE_C;
      idli_dcd_pkg::STATE_NOP_0: state_d = idli_dcd_pkg::STATE_NOP_1;
      idli_dcd_pkg::STATE_IMM_0: state_d = idli_dcd_pkg::STATE_IMM_1;
      idli_dcd_pkg::STATE_IMM_1: state_d = idli_dcd_pkg::STATE_IMM_2;
      idli_dcd_pkg::STATE_IMM_2: state_d = idli_dcd_pkg::STATE_IMM_3;
      idli_dcd_pkg::STATE_IMM_3: state_d = idli_dcd_pkg::STATE_INIT;
      default: begin
        // The final cycle of an instruction. An immediate follows when C
        // selects it, but a redirect means the stream restarts at a new
        // instruction instead.
        if (i_seq_rhs_src == idli_isa_pkg::RHS_SRC_IMM && !i_dcd_ex_redirect) begin
          state_d = idli_dcd_pkg::STATE_IMM_0;
        end else begin
          state_d = idli_dcd_pkg::STATE_INIT;
        end
      end
    endcase
  end

  always_comb o_seq_state = state_q;

  // The cycle is encoded in the top of the state.
  always_comb o_seq_cycle = state_q[5:4];

  // Fields are held on every nibble but the last, as the last one is
  // presented live.
  always_comb o_seq_capture = i_dcd_enc_vld && o_seq_cycle != 2'd3;

  // NOPs are dropped here and immediate data is never an operation.
  always_comb begin
    o_dcd_op_vld = o_seq_cycle == 2'd3
                && state_q != idli_dcd_pkg::STATE_NOP_1
                && state_q != idli_dcd_pkg::STATE_IMM_3;
  end

endmodule

/* hdl/idli_dcd_pkg.sv */
// Types used only inside the decoder.
package idli_dcd_pkg;

  // Decode cycle of the current instruction, one per nibble.
  typedef logic [1:0] cycle_t;

  // Decode state. The top two bits of every state give the cycle, so the
  // cycle never needs a counter of its own.
  typedef enum logic [5:0] {
    // Cycle 0 sees the opcode nibble.
    STATE_INIT         = 6'b000000,
    STATE_IMM_0        = 6'b001111,

    // Cycle 1 has the opcode path known.
    STATE_NOP_BZ       = 6'b010000,
    STATE_EQ_LT        = 6'b010001,
    STATE_GE           = 6'b010010,
    STATE_ADD_SUB      = 6'b011000,
    STATE_AND_ANDN     = 6'b011001,
    STATE_OR_XOR       = 6'b011010,
    STATE_MOV_PC_BP_JP = 6'b011011,
    STATE_IMM_1        = 6'b011111,

    // Cycle 2 is left with operand parsing and a few control bits.
    STATE_NOP_0        = 6'b100000,
    STATE_BZ           = 6'b100001,
    STATE_QBC          = 6'b100010,
    STATE_ABC          = 6'b100100,
    STATE_BP_JP        = 6'b100111,
    STATE_MOV_PC       = 6'b101000,
    STATE_IMM_2        = 6'b101111,

    // Cycle 3 completes the instruction.
    STATE_NOP_1        = 6'b110000,
    STATE_BC           = 6'b110001,
    STATE_C            = 6'b110010,
    STATE_IMM_3        = 6'b111111
  } state_t;

endpackage

/* hdl/idli_isa_pkg.sv */
// Types of the instruction set that the decoder and the execute side share.
package idli_isa_pkg;

  // One nibble of the serial instruction stream.
  typedef logic [3:0] sqi_data_t;

  // Index of a general register.
  typedef logic [2:0] greg_t;

  // A C field of 7 takes the right operand from the immediate that
  // follows the instruction.
  localparam greg_t GREG_IMM = 3'd7;

  // Index of a predicate register.
  typedef logic [1:0] preg_t;

  // Predicate register 3 always reads as true.
  localparam preg_t PREG_PT = 2'd3;

  // Source of the left operand of the ALU.
  typedef enum logic [1:0] {
    LHS_SRC_REG  = 2'd0,
    LHS_SRC_PC   = 2'd1,
    LHS_SRC_ZERO = 2'd2
  } lhs_src_t;

  // Source of the right operand of the ALU.
  typedef enum logic {
    RHS_SRC_REG = 1'b0,
    RHS_SRC_IMM = 1'b1
  } rhs_src_t;

  // ALU operation. Subtraction is an add with inverted rhs and carry in.
  typedef enum logic [1:0] {
    ALU_OP_ADD = 2'd0,
    ALU_OP_AND = 2'd1,
    ALU_OP_OR  = 2'd2,
    ALU_OP_XOR = 2'd3
  } alu_op_t;

  // Comparison applied to the result of the subtraction.
  typedef enum logic [1:0] {
    CMP_OP_EQ = 2'd0,
    CMP_OP_NE = 2'd1,
    CMP_OP_LT = 2'd2,
    CMP_OP_GE = 2'd3
  } cmp_op_t;

  // Register fields of an instruction and which of them are read.
  typedef struct packed {
    preg_t p;
    preg_t q;
    greg_t a;
    greg_t b;
    greg_t c;
    logic  a_vld;
    logic  b_vld;
    logic  c_vld;
    logic  q_vld;
  } opnd_t;

  // Execute controls of an instruction.
  typedef struct packed {
    lhs_src_t lhs_src;
    rhs_src_t rhs_src;
    alu_op_t  alu_op;
    logic     alu_cin;
    logic     alu_rhs_inv;
    cmp_op_t  cmp_op;
    logic     cmp_signed;
    logic     wr_pc;
    logic     wr_lr;
    logic     p_inv;
  } ctrl_t;

  // Fully decoded operation as handed to execute.
  typedef struct packed {
    opnd_t opnd;
    ctrl_t ctrl;
  } op_t;

endpackage
